//--- correlatorBank.sv
// Correlator bank
module correlatorBank #(
    parameter int NumMics = 3,
    parameter int MaxLags = 4
) (
    input  logic                                                         clk,
    input  logic                                                         rstN,

    input  tdoaPkg::sample_t [NumMics-1:0]                               samples,
    input  logic                                                         sampleValid,
    input  logic                                                         frameLast,

    output tdoaPkg::xcorr_t [tdoaPkg::numPairs(NumMics)-1:0][2*MaxLags:0] xcorrs,
    output logic                                                         xcorrValid
);

    localparam int NumPairs = tdoaPkg::numPairs(NumMics);

    logic frameStart;   // next accepted sample opens a frame
    logic frameDone;    // accumulators took the last sample of a frame

    tdoaPkg::xcorr_t [NumPairs-1:0][2*MaxLags:0] pairSums;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frameStart <= 1'b1;
            frameDone  <= 1'b0;
            xcorrValid <= 1'b0;
        end else begin
            if (sampleValid) begin
                frameStart <= frameLast;
            end
            frameDone  <= sampleValid & frameLast;
            xcorrValid <= frameDone;
        end
    end

    // finished sums are held here until the next frame ends
    always_ff @(posedge clk) begin
        if (frameDone) begin
            xcorrs <= pairSums;
        end
    end

    for (genvar a = 0; a < NumMics - 1; a++) begin : gMicA
        for (genvar b = a + 1; b < NumMics; b++) begin : gMicB
            localparam int Pair = a*NumMics - a*(a+1)/2 + (b - a - 1);

            pairCorrelator #(
                .MaxLags     (MaxLags)
            ) uPairCorr (
                .clk         (clk),
                .rstN        (rstN),
                .frameStart  (frameStart),
                .sampleValid (sampleValid),
                .sampleA     (samples[a]),
                .sampleB     (samples[b]),
                .sums        (pairSums[Pair])
            );
        end
    end

endmodule

//--- files.f
+incdir+.
tdoaPkg.sv
pairCorrelator.sv
correlatorBank.sv
lagPeakFinder.sv
peakSequencer.sv
peakSearch.sv
tdoaEstimator.sv
tdoaTb.sv

//--- lagPeakFinder.sv
// Lag peak finder
module lagPeakFinder #(
    parameter int MaxLags     = 4,
    parameter int MinXcorrVal = 1000
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          clear,

    input  tdoaPkg::xcorr_t [2*MaxLags:0] xcorrs,
    input  tdoaPkg::lagIdx_t              lagIdx,
    input  logic                          step,

    output tdoaPkg::peakResult_t          peak
);

    localparam tdoaPkg::xcorr_t  Threshold = tdoaPkg::xcorr_t'(MinXcorrVal);
    localparam tdoaPkg::lagIdx_t LastLag   = tdoaPkg::lagIdx_t'(2*MaxLags);

    tdoaPkg::xcorr_t bestVal;     // never below the threshold
    tdoaPkg::xcorr_t candidate;
    logic            better;

    assign candidate = xcorrs[lagIdx];

    // strict compare keeps the lowest index on ties and rejects the threshold itself
    assign better = candidate > bestVal;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bestVal <= Threshold;
            peak    <= '0;
        end else if (clear) begin
            bestVal <= Threshold;
            peak    <= '0;
        end else if (step && better) begin
            bestVal     <= candidate;
            peak.found  <= 1'b1;
            peak.lagIdx <= lagIdx;
        end
    end

    // the sequencer must stop at the last lag of the window
    lagInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        step |-> (lagIdx <= LastLag)
    ) else $error("lagPeakFinder: lag index %0d is past the last lag %0d", lagIdx, LastLag);

endmodule

//--- pairCorrelator.sv
// Pair cross-correlator
module pairCorrelator #(
    parameter int MaxLags = 4
) (
    input  logic                          clk,
    input  logic                          rstN,

    input  logic                          frameStart,
    input  logic                          sampleValid,
    input  tdoaPkg::sample_t              sampleA,
    input  tdoaPkg::sample_t              sampleB,

    output tdoaPkg::xcorr_t [2*MaxLags:0] sums
);

    localparam int NumLags = 2*MaxLags + 1;

    // stored history, the newest input completes each delay line
    tdoaPkg::sample_t [MaxLags-1:0] aHist;   // aHist[j] holds a[n-1-j]
    tdoaPkg::sample_t [NumLags-2:0] bHist;   // bHist[j] holds b[n-1-j]

    // full delay lines as seen by the current sample
    tdoaPkg::sample_t [MaxLags:0]   aTaps;
    tdoaPkg::sample_t [NumLags-1:0] bTaps;
    tdoaPkg::sample_t               aDelayed;

    tdoaPkg::xcorr_t  [NumLags-1:0] products;
    tdoaPkg::xcorr_t  [NumLags-1:0] acc;

    // a new frame sees empty history, so older taps read as zero
    always_comb begin
        aTaps[0] = sampleA;
        for (int j = 1; j <= MaxLags; j++) begin
            aTaps[j] = frameStart ? '0 : aHist[j-1];
        end
        bTaps[0] = sampleB;
        for (int k = 1; k < NumLags; k++) begin
            bTaps[k] = frameStart ? '0 : bHist[k-1];
        end
    end

    assign aDelayed = aTaps[MaxLags];   // a[n-MaxLags] centres the lag window

    // lag k pairs a[n-MaxLags] with b[n-k]
    always_comb begin
        for (int k = 0; k < NumLags; k++) begin
            products[k] = aDelayed * bTaps[k];
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            aHist <= aTaps[MaxLags-1:0];
            bHist <= bTaps[NumLags-2:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (sampleValid) begin
            for (int k = 0; k < NumLags; k++) begin
                acc[k] <= (frameStart ? '0 : acc[k]) + products[k];
            end
        end
    end

    assign sums = acc;

endmodule

//--- peakSearch.sv
// Peak search over lag sums
module peakSearch #(
    parameter int NumMics     = 3,
    parameter int MaxLags     = 4,
    parameter int MinXcorrVal = 1000
) (
    input  logic                                                         clk,
    input  logic                                                         rstN,

    input  tdoaPkg::xcorr_t [tdoaPkg::numPairs(NumMics)-1:0][2*MaxLags:0] xcorrs,
    input  logic                                                         xcorrValid,

    output tdoaPkg::peakResult_t [tdoaPkg::numPairs(NumMics)-1:0]         peaks,
    output logic                                                         peaksValid
);

    localparam int NumPairs = tdoaPkg::numPairs(NumMics);

    tdoaPkg::xcorr_t [NumPairs-1:0][2*MaxLags:0] xcorrReg;
    tdoaPkg::peakResult_t [NumPairs-1:0]         finderPeaks;
    tdoaPkg::peakResult_t [NumPairs-1:0]         peakReg;

    logic             busy;
    logic             clear;
    logic             step;
    logic             done;
    tdoaPkg::lagIdx_t lagIdx;

    if (2*MaxLags > 2**tdoaPkg::LagIdxBits - 1) begin : gLagLimit
        $error("peakSearch: MaxLags %0d does not fit the lag index", MaxLags);
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            xcorrReg <= xcorrs;   // only taken when the sequencer accepts the set
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            peakReg <= '0;
        end else if (done) begin
            peakReg <= finderPeaks;
        end
    end

    // finders are final during done, afterwards the held copy is shown
    assign peaks      = done ? finderPeaks : peakReg;
    assign peaksValid = done;

    peakSequencer #(
        .MaxLags (MaxLags)
    ) uSeq (
        .clk     (clk),
        .rstN    (rstN),
        .start   (xcorrValid),
        .busy    (busy),
        .clear   (clear),
        .step    (step),
        .done    (done),
        .lagIdx  (lagIdx)
    );

    for (genvar p = 0; p < NumPairs; p++) begin : gFinder
        lagPeakFinder #(
            .MaxLags     (MaxLags),
            .MinXcorrVal (MinXcorrVal)
        ) uFinder (
            .clk         (clk),
            .rstN        (rstN),
            .clear       (clear),
            .xcorrs      (xcorrReg[p]),
            .lagIdx      (lagIdx),
            .step        (step),
            .peak        (finderPeaks[p])
        );
    end

    // frames shorter than 2*MaxLags+2 samples overrun the scan
    noBusyDrop: assert property (
        @(posedge clk) disable iff (!rstN)
        xcorrValid |-> !busy
    ) else $error("peakSearch: correlation set arrived during a scan and was dropped");

endmodule

//--- peakSequencer.sv
// Peak search sequencer
module peakSequencer #(
    parameter int MaxLags = 4
) (
    input  logic             clk,
    input  logic             rstN,

    input  logic             start,

    output logic             busy,
    output logic             clear,
    output logic             step,
    output logic             done,
    output tdoaPkg::lagIdx_t lagIdx
);

    localparam tdoaPkg::lagIdx_t LastLag = tdoaPkg::lagIdx_t'(2*MaxLags);

    typedef enum logic [1:0] {
        Idle,
        Scan,
        Finish
    } state_t;

    state_t state;

    // a new set may start while the previous results are shown
    assign busy  = (state == Scan);
    assign step  = (state == Scan);
    assign clear = start && (state != Scan);
    assign done  = (state == Finish);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= Idle;
            lagIdx <= '0;
        end else begin
            case (state)
                Idle, Finish: begin
                    state <= start ? Scan : Idle;
                end
                Scan: begin
                    if (lagIdx == LastLag) begin
                        state  <= Finish;
                        lagIdx <= '0;
                    end else begin
                        lagIdx <= lagIdx + 1'b1;
                    end
                end
                default: begin
                    state  <= Idle;
                    lagIdx <= '0;
                end
            endcase
        end
    end

    donePulse: assert property (
        @(posedge clk) disable iff (!rstN)
        done |=> !done
    ) else $error("peakSequencer: done held for more than one cycle");

endmodule

//--- tdoaEstimator.sv
// TDOA estimator top level
module tdoaEstimator #(
    parameter int NumMics     = 3,
    parameter int MaxLags     = 4,
    parameter int MinXcorrVal = 1000
) (
    input  logic                                                 clk,
    input  logic                                                 rstN,

    input  tdoaPkg::sample_t [NumMics-1:0]                       samples,
    input  logic                                                 sampleValid,
    input  logic                                                 frameLast,

    output tdoaPkg::peakResult_t [tdoaPkg::numPairs(NumMics)-1:0] peaks,
    output logic                                                 peaksValid
);

    localparam int NumPairs = tdoaPkg::numPairs(NumMics);

    tdoaPkg::xcorr_t [NumPairs-1:0][2*MaxLags:0] xcorrs;
    logic                                        xcorrValid;

    correlatorBank #(
        .NumMics     (NumMics),
        .MaxLags     (MaxLags)
    ) uBank (
        .clk         (clk),
        .rstN        (rstN),
        .samples     (samples),
        .sampleValid (sampleValid),
        .frameLast   (frameLast),
        .xcorrs      (xcorrs),
        .xcorrValid  (xcorrValid)
    );

    peakSearch #(
        .NumMics     (NumMics),
        .MaxLags     (MaxLags),
        .MinXcorrVal (MinXcorrVal)
    ) uSearch (
        .clk         (clk),
        .rstN        (rstN),
        .xcorrs      (xcorrs),
        .xcorrValid  (xcorrValid),
        .peaks       (peaks),
        .peaksValid  (peaksValid)
    );

endmodule

//--- tdoaPkg.sv
// TDOA shared types
package tdoaPkg;

    // word widths
    localparam int SampleBits = 12;
    localparam int XcorrBits  = 32;   // holds 2*SampleBits plus growth over a frame
    localparam int LagIdxBits = 8;    // enough for 2*MaxLags with MaxLags up to 127

    // one signed microphone sample
    typedef logic signed [SampleBits-1:0] sample_t;

    // one signed cross-correlation sum
    typedef logic signed [XcorrBits-1:0] xcorr_t;

    // lag index, 0 is the most negative lag and 2*MaxLags the most positive
    typedef logic [LagIdxBits-1:0] lagIdx_t;

    // peak search result for one microphone pair
    typedef struct packed {
        logic    found;    // a lag sum went above the threshold
        lagIdx_t lagIdx;   // first maximum, zero when nothing was found
    } peakResult_t;

    // pairs run (0,1), (0,2) .. (0,N-1), (1,2) .. in every block that indexes them
    function automatic int numPairs(input int numMics);
        return numMics * (numMics - 1) / 2;
    endfunction

endpackage

//--- tdoaRefModel.svh
// TDOA reference model
`ifndef TDOA_REF_MODEL_SVH
`define TDOA_REF_MODEL_SVH

// pairs run (0,1), (0,2) .. (0,N-1), (1,2) and so on
function automatic void pairMics(input int pair, output int micA, output int micB);
    int idx;
    idx  = 0;
    micA = 0;
    micB = 1;
    for (int a = 0; a < NumMics - 1; a++) begin
        for (int b = a + 1; b < NumMics; b++) begin
            if (idx == pair) begin
                micA = a;
                micB = b;
            end
            idx++;
        end
    end
endfunction

function automatic int frameSample(input int mic, input int n);
    if (n < 0) begin
        return 0;   // nothing exists before the frame starts
    end
    return frameMem[n][mic];
endfunction

// lag k sums a[n-MaxLags]*b[n-k] over the frame, wrapping like a 32-bit sum
function automatic int lagSum(input int micA, input int micB, input int k, input int len);
    int sum;
    sum = 0;
    for (int n = 0; n < len; n++) begin
        sum += frameSample(micA, n - MaxLags) * frameSample(micB, n - k);
    end
    return sum;
endfunction

function automatic tdoaPkg::peakResult_t pairPeak(input int pair, input int len);
    int micA;
    int micB;
    int best;
    int sum;
    tdoaPkg::peakResult_t res;
    pairMics(pair, micA, micB);
    best = MinXcorrVal;   // a sum must beat the threshold and every earlier sum
    res  = '0;
    for (int k = 0; k < NumLags; k++) begin
        sum = lagSum(micA, micB, k, len);
        if (sum > best) begin
            best       = sum;
            res.found  = 1'b1;
            res.lagIdx = tdoaPkg::lagIdx_t'(k);
        end
    end
    return res;
endfunction

function automatic peakSet_t framePeaks(input int len);
    peakSet_t set;
    for (int p = 0; p < NumPairs; p++) begin
        set[p] = pairPeak(p, len);
    end
    return set;
endfunction

`endif

//--- tdoaTb.sv
// TDOA estimator testbench
module tdoaTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumMics     = 3;
    localparam int MaxLags     = 4;
    localparam int MinXcorrVal = 1000;
    localparam int NumPairs    = tdoaPkg::numPairs(NumMics);
    localparam int NumLags     = 2*MaxLags + 1;
    localparam int ResultDelay = 2*MaxLags + 3;   // frameLast edge to peaksValid
    localparam int MaxFrame    = 32;
    localparam int NumRows     = 14;
    localparam int ClkPeriod   = 40;

    typedef enum logic [1:0] {DelayedCopy, Scaled, Constant, RandomNoise} pattern_t;

    typedef struct packed {
        int                      frameLen;
        pattern_t                kind;
        logic [0:NumMics-1][7:0] delay;   // delay of each microphone in samples
        int                      amplitude;
        logic                    resetMid;
    } row_t;

    typedef tdoaPkg::peakResult_t [NumPairs-1:0] peakSet_t;

    typedef struct packed {
        int       row;
        int       acceptCycle;
        peakSet_t peaks;
    } expect_t;

    logic                          clk = 1'b0;
    logic                          rstN;
    tdoaPkg::sample_t [NumMics-1:0] samples;
    logic                          sampleValid;
    logic                          frameLast;
    peakSet_t                      peaks;
    logic                          peaksValid;

    row_t     rows [NumRows];
    int       frameMem [MaxFrame][NumMics];
    expect_t  pendingQ [$];
    peakSet_t heldPeaks = '0;   // last expected result, shown until the next pulse
    integer   seed = 32'h360dc659;
    int       cycleCount = 0;
    int       checkCount = 0;
    int       errorCount = 0;
    int       framesSeen = 0;
    logic     tableReady = 1'b0;

    `include "tdoaRefModel.svh"

    tdoaEstimator #(
        .NumMics     (NumMics),
        .MaxLags     (MaxLags),
        .MinXcorrVal (MinXcorrVal)
    ) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .samples     (samples),
        .sampleValid (sampleValid),
        .frameLast   (frameLast),
        .peaks       (peaks),
        .peaksValid  (peaksValid)
    );

    always #(ClkPeriod/2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic fillTable();
        rows[0]  = '{20, DelayedCopy, '{8'd0, 8'd2, 8'd0}, 500, 1'b0};
        rows[1]  = '{24, DelayedCopy, '{8'd0, 8'd3, 8'd1}, 800, 1'b0};
        rows[2]  = '{16, RandomNoise, '{8'd0, 8'd0, 8'd0}, 3, 1'b0};   // all sums stay small
        rows[3]  = '{12, Constant, '{8'd0, 8'd0, 8'd0}, 10, 1'b0};
        rows[4]  = '{16, Constant, '{8'd0, 8'd0, 8'd0}, 40, 1'b0};     // tied sums
        rows[5]  = '{16, Constant, '{8'd2, 8'd0, 8'd1}, 40, 1'b0};
        rows[6]  = '{10, RandomNoise, '{8'd0, 8'd0, 8'd0}, 1000, 1'b0};
        rows[7]  = '{10, DelayedCopy, '{8'd0, 8'd1, 8'd3}, 700, 1'b0};
        rows[8]  = '{10, Scaled, '{8'd0, 8'd1, 8'd2}, 400, 1'b0};
        rows[9]  = '{18, RandomNoise, '{8'd0, 8'd0, 8'd0}, 2047, 1'b1};
        rows[10] = '{10, RandomNoise, '{8'd0, 8'd0, 8'd0}, 1500, 1'b0};
        rows[11] = '{30, RandomNoise, '{8'd0, 8'd0, 8'd0}, 2047, 1'b0};
        rows[12] = '{14, Scaled, '{8'd1, 8'd0, 8'd4}, 600, 1'b1};
        rows[13] = '{10, DelayedCopy, '{8'd0, 8'd4, 8'd2}, 900, 1'b0};
    endtask

    task automatic buildFrame(input row_t r);
        int base [MaxFrame];
        int d;
        int s;
        for (int n = 0; n < r.frameLen; n++) begin
            base[n] = $random(seed) % (r.amplitude + 1);
        end
        for (int n = 0; n < r.frameLen; n++) begin
            for (int m = 0; m < NumMics; m++) begin
                d = int'(r.delay[m]);
                case (r.kind)
                    DelayedCopy: s = (n >= d) ? base[n - d] : 0;
                    Scaled:      s = ((n >= d) ? base[n - d] : 0) * (m + 1);
                    Constant:    s = (n >= d) ? r.amplitude : 0;
                    default:     s = $random(seed) % (r.amplitude + 1);
                endcase
                frameMem[n][m] = s;
            end
        end
    endtask

    // called 2 ns after a rising edge and returns at the same point of a later cycle
    task automatic driveSamples(input int rowIdx, input int len, input logic complete);
        expect_t e;
        e.row   = rowIdx;
        e.peaks = framePeaks(len);
        for (int n = 0; n < len; n++) begin
            for (int m = 0; m < NumMics; m++) begin
                samples[m] = tdoaPkg::sample_t'(frameMem[n][m]);
            end
            sampleValid = 1'b1;
            frameLast   = complete && (n == len - 1);
            @(posedge clk);
            #2;
        end
        e.acceptCycle = cycleCount;
        sampleValid   = 1'b0;
        frameLast     = 1'b0;
        if (complete) begin
            pendingQ.push_back(e);
        end
    endtask

    task automatic resetMidFrame(input int rowIdx, input int len);
        sampleValid = 1'b0;
        while (pendingQ.size() != 0) begin
            @(posedge clk);
            #2;
        end
        driveSamples(rowIdx, len / 2, 1'b0);
        rstN = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        rstN = 1'b1;
    endtask

    task automatic checkResult(input expect_t e);
        int rowErrors;
        int delay;
        rowErrors = 0;
        delay     = cycleCount - e.acceptCycle;
        checkCount++;
        assert (delay == ResultDelay) else begin
            $display("[FAIL] %0d ns: row %0d peaksValid came %0d cycles after frameLast, not %0d",
                     $time, e.row, delay, ResultDelay);
            rowErrors++;
        end
        for (int p = 0; p < NumPairs; p++) begin
            checkCount++;
            assert (peaks[p] === e.peaks[p]) else begin
                $display("[FAIL] %0d ns: row %0d pair %0d expected found=%0b lag=%0d, got %0b/%0d",
                         $time, e.row, p, e.peaks[p].found, e.peaks[p].lagIdx,
                         peaks[p].found, peaks[p].lagIdx);
                rowErrors++;
            end
        end
        errorCount += rowErrors;
        framesSeen++;
        heldPeaks = e.peaks;
        $display("row %0d: %0d of %0d checks failed", e.row, rowErrors, NumPairs + 1);
    endtask

    // sampled mid-cycle away from the edge where the DUT updates
    always @(negedge clk) begin
        if (!rstN) begin
            heldPeaks = '0;
            checkCount++;
            assert (peaksValid === 1'b0) else begin
                $display("[FAIL] %0d ns: peaksValid high during reset", $time);
                errorCount++;
            end
        end else if (peaksValid === 1'b1) begin
            assert (pendingQ.size() != 0) else begin
                $display("at %0d ns peaksValid pulsed with no frame waiting for results", $time);
                errorCount++;
            end
            if (pendingQ.size() != 0) begin
                checkResult(pendingQ.pop_front());
            end
        end else begin
            checkCount++;
            assert (peaks === heldPeaks) else begin
                $display("[FAIL] %0d ns: peaks changed while peaksValid was low", $time);
                errorCount++;
            end
            if (pendingQ.size() != 0) begin
                assert (cycleCount - pendingQ[0].acceptCycle <= ResultDelay) else begin
                    $display("row %0d: no peak result arrived within %0d cycles of frameLast",
                             pendingQ[0].row, ResultDelay);
                    errorCount++;
                    void'(pendingQ.pop_front());
                end
            end
        end
    end

    initial begin
        samples     = '0;
        sampleValid = 1'b0;
        frameLast   = 1'b0;
        rstN        = 1'b0;
        fillTable();
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int r = 0; r < NumRows; r++) begin
            buildFrame(rows[r]);
            if (rows[r].resetMid) begin
                resetMidFrame(r, rows[r].frameLen);
            end
            driveSamples(r, rows[r].frameLen, 1'b1);   // next row follows back to back
        end
        while (pendingQ.size() != 0) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        $display("rows %0d, frames checked %0d, checks %0d, errors %0d",
                 NumRows, framesSeen, checkCount, errorCount);
        if (errorCount == 0 && framesSeen == NumRows) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        int budget;
        wait (tableReady);
        budget = 2;
        for (int r = 0; r < NumRows; r++) begin
            budget += rows[r].frameLen + 2*MaxLags + 10;
            if (rows[r].resetMid) begin
                budget += rows[r].frameLen / 2 + 2;   // partial frame and reset cycles
            end
        end
        #(budget * ClkPeriod);
        $display("watchdog: peak results never arrived within %0d clock cycles", budget);
        $display("test failed");
        $finish;
    end

endmodule
